//--- strand_core.f
common/core_pkg.sv
source/strand_select_stage.sv
source/decode_stage.sv
source/register_file.sv
execute/execute_stage.sv
execute/writeback_stage.sv
source/rollback_controller.sv
source/strand_core.sv
verif/strand_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module strand_core_tb \
	-f strand_core.f -o strand_core_sim
out=$(./obj_dir/strand_core_sim 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q '^Simulation finished: PASS$'

//--- verif/strand_core_tb.sv
`timescale 1ns/100ps

module strand_core_tb;

	import core_pkg::*;

	localparam int STRANDS = 4;
	localparam int NUM_ROWS = 5;
	localparam int RANDOM_ROW = 4;
	localparam int RESET_CYCLES = 16;

	logic clk;
	logic rst_n_i;
	logic start_i;
	word_t idata_i = '0;
	pc_t iaddress_o;
	logic iaccess_o;
	commit_t commit_o;
	logic halt_o;

	word_t rom [256];
	pc_t fetch_addr_q = '0;	// address sent in the previous cycle
	commit_t exp_q [$];	// expected writes of all strands in program order per strand
	word_t model_regs [STRANDS][8];
	word_t seen_regs [STRANDS][8];
	int errors = 0;
	int commits = 0;
	int cycles = 0;
	int cycle_limit = 0;

	// program kind per strand is 0 for halt only, 1 for arithmetic with wrap,
	// 2 for a dependent chain and 3 for a countdown loop, and the param feeds the first immediate
	int row_kind [NUM_ROWS][STRANDS] = '{'{1, 1, 1, 1}, '{2, 0, 0, 0}, '{3, 1, 3, 2},
		'{0, 3, 0, 0}, '{1, 2, 1, 2}};
	logic [15:0] row_param [NUM_ROWS][STRANDS] = '{'{16'd5, 16'hfffd, 16'h7fff, 16'd1},
		'{16'd11, 16'd0, 16'd0, 16'd0}, '{16'd4, 16'd100, 16'd1, 16'd9},
		'{16'd0, 16'd5, 16'd0, 16'd0}, '{16'd0, 16'd0, 16'd0, 16'd0}};
	word_t row_expect [NUM_ROWS][STRANDS] = '{'{32'd9, 32'hfffffff9, 32'h0000fffd, 32'd1},
		'{32'd51, 32'd0, 32'd0, 32'd0}, '{32'd12, 32'd199, 32'd3, 32'd43},
		'{32'd0, 32'd15, 32'd0, 32'd0}, '{32'd0, 32'd0, 32'd0, 32'd0}};

	strand_core #(.NUM_STRANDS(STRANDS)) DUT(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.start_i(start_i),
		.idata_i(idata_i),
		.iaddress_o(iaddress_o),
		.iaccess_o(iaccess_o),
		.commit_o(commit_o),
		.halt_o(halt_o));

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	function automatic word_t encode(input logic [3:0] op, input int rd, input int rs1,
		input int rs2, input logic [15:0] imm);
		return {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000, imm};
	endfunction

	function automatic int result_reg(input int kind);
		case (kind)
			1: return 6;
			2: return 5;
			3: return 2;
			default: return 1;
		endcase
	endfunction

	task automatic emit_program(input int s, input int kind, input logic [15:0] p);
		int a;
		a = s * 64;
		case (kind)
			1:
			begin
				rom[a] = encode(OP_ADDI, 1, 0, 0, p);
				rom[a + 1] = encode(OP_ADDI, 2, 0, 0, 16'hffff);
				rom[a + 2] = encode(OP_ADD, 3, 1, 2, 16'h0);
				rom[a + 3] = encode(OP_SUB, 4, 0, 1, 16'h0);
				rom[a + 4] = encode(OP_ADD, 5, 2, 2, 16'h0);	// wraps to fffffffe
				rom[a + 5] = encode(4'hf, 1, 1, 1, 16'h1234);	// unknown code
				rom[a + 6] = encode(OP_SUB, 6, 3, 4, 16'h0);
				rom[a + 7] = encode(OP_HALT, 0, 0, 0, 16'h0);
			end
			2:
			begin
				rom[a] = encode(OP_ADDI, 1, 0, 0, p);
				rom[a + 1] = encode(OP_ADD, 2, 1, 1, 16'h0);
				rom[a + 2] = encode(OP_ADD, 3, 2, 1, 16'h0);
				rom[a + 3] = encode(OP_SUB, 4, 3, 2, 16'h0);
				rom[a + 4] = encode(OP_ADDI, 1, 4, 0, 16'd7);
				rom[a + 5] = encode(OP_ADD, 5, 1, 3, 16'h0);
				rom[a + 6] = encode(OP_HALT, 0, 0, 0, 16'h0);
			end
			3:
			begin
				rom[a] = encode(OP_ADDI, 1, 0, 0, p);	// loop count
				rom[a + 1] = encode(OP_ADDI, 2, 2, 0, 16'd3);
				rom[a + 2] = encode(OP_ADDI, 1, 1, 0, 16'hffff);
				rom[a + 3] = encode(OP_BNZ, 0, 1, 0, 16'hfffd);	// back to a + 1
				rom[a + 4] = encode(OP_ADDI, 3, 0, 0, 16'd99);
				rom[a + 5] = encode(OP_HALT, 0, 0, 0, 16'h0);
				rom[a + 6] = encode(OP_ADDI, 7, 0, 0, 16'd1);	// must never commit
			end
			default:
				rom[a] = encode(OP_HALT, 0, 0, 0, 16'h0);
		endcase
	endtask

	task automatic build_row(input int row);
		for (int a = 0; a < 256; a++)
			rom[a] = {4'h0, 12'(a * 29), 8'(a), 8'(a ^ 8'h5a)};	// nop words
		for (int s = 0; s < STRANDS; s++)
			emit_program(s, row_kind[row][s], row_param[row][s]);
	endtask

	task automatic record_write(input int s, input reg_idx_t rd, input word_t v);
		model_regs[s][rd] = v;
		exp_q.push_back('{valid: 1'b1, strand: STRAND_W'(s), rd: rd, value: v});
	endtask

	// instruction set reference that runs one strand from its base to HALT
	task automatic interpret(input int s, output int steps);
		pc_t pc;
		word_t w;
		word_t a;
		word_t b;
		word_t imm;
		logic done;
		pc = pc_t'(s * 64);
		steps = 0;
		done = 1'b0;
		for (int r = 0; r < 8; r++)
			model_regs[s][r] = '0;
		while (!done && steps < 256)
		begin
			w = rom[pc];
			a = model_regs[s][w[24:22]];
			b = model_regs[s][w[21:19]];
			imm = {{16{w[15]}}, w[15:0]};
			steps++;
			pc = pc + 8'd1;
			case (w[31:28])
				OP_ADD: record_write(s, w[27:25], a + b);
				OP_SUB: record_write(s, w[27:25], a - b);
				OP_ADDI: record_write(s, w[27:25], a + imm);
				OP_BNZ: if (a != '0) pc = pc + imm[7:0];
				OP_HALT: done = 1'b1;
				default: ;
			endcase
		end
	endtask

	task automatic check_commit(input commit_t got, input commit_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: strand %0d wrote r%0d=%h, expected strand %0d r%0d=%h",
				$time, got.strand, got.rd, got.value, exp.strand, exp.rd, exp.value);
		end
	endtask

	task automatic check_regs(input word_t got, input word_t exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_idle(input string phase);
		if (iaccess_o !== 1'b0 || commit_o.valid !== 1'b0 || halt_o !== 1'b0)
		begin
			errors++;
			$display("outputs not idle %s at %0t: iaccess_o=%b commit valid=%b halt_o=%b",
				phase, $time, iaccess_o, commit_o.valid, halt_o);
		end
	endtask

	task automatic reset_and_start();
		@(negedge clk);
		rst_n_i = 1'b0;
		start_i = 1'b0;
		repeat (RESET_CYCLES)
		begin
			@(negedge clk);
			check_idle("in reset");
		end
		rst_n_i = 1'b1;
		repeat (3)
		begin
			@(negedge clk);
			check_idle("before start");
		end
		start_i = 1'b1;
		@(negedge clk);
		start_i = 0;
	endtask

	// memory answers one cycle late and commits are matched per strand in order
	always @(negedge clk)
	begin
		int idx;
		idx = -1;
		idata_i = rom[fetch_addr_q];
		fetch_addr_q = iaddress_o;
		if (commit_o.valid === 1'b1)
		begin
			for (int i = 0; i < exp_q.size(); i++)
				if (idx < 0 && exp_q[i].strand == commit_o.strand)
					idx = i;
			if (halt_o)
			begin
				errors++;
				$display("commit from strand %0d at %0t after halt_o rose",
					commit_o.strand, $time);
			end
			if (idx < 0)
			begin
				errors++;
				$display("unexpected commit from strand %0d to r%0d at %0t, no write was left",
					commit_o.strand, commit_o.rd, $time);
			end
			else
			begin
				check_commit(commit_o, exp_q[idx]);
				exp_q.delete(idx);
			end
			seen_regs[commit_o.strand][commit_o.rd] = commit_o.value;
			commits++;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("timeout: halt_o did not rise within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial
	begin
		int total_steps;
		int steps;
		int failed_tests;
		int errors_before;
		word_t sx;
		total_steps = 0;
		failed_tests = 0;
		rst_n_i = 1'b0;
		start_i = 1'b0;
		void'($urandom(32'hf1c556d5));
		for (int s = 0; s < STRANDS; s++)
		begin
			row_param[RANDOM_ROW][s] = 16'($urandom);
			sx = {{16{row_param[RANDOM_ROW][s][15]}}, row_param[RANDOM_ROW][s]};
			row_expect[RANDOM_ROW][s] = (row_kind[RANDOM_ROW][s] == 1) ? 2 * sx - 1 : 4 * sx + 7;
		end
		for (int row = 0; row < NUM_ROWS; row++)
		begin
			build_row(row);
			for (int s = 0; s < STRANDS; s++)
			begin
				interpret(s, steps);
				total_steps += steps;
			end
		end
		exp_q.delete();
		cycle_limit = total_steps * 4 + NUM_ROWS * (RESET_CYCLES + 64);	// one turn per instruction
		for (int row = 0; row < NUM_ROWS; row++)
		begin
			errors_before = errors;
			commits = 0;
			build_row(row);
			for (int s = 0; s < STRANDS; s++)
			begin
				interpret(s, steps);
				for (int r = 0; r < 8; r++)
					seen_regs[s][r] = '0;
			end
			reset_and_start();
			while (!halt_o)
			begin
				if (iaccess_o !== 1'b1)
				begin
					errors++;
					$display("no fetch issued at %0t while a strand was still running", $time);
				end
				@(negedge clk);
			end
			repeat (4)
			begin
				@(negedge clk);
				if (iaccess_o)
				begin
					errors++;
					$display("fetch issued at %0t after halt_o rose", $time);
				end
			end
			@(posedge clk);
			if (exp_q.size() != 0)
			begin
				errors++;
				$display("%0d expected commits never appeared in test %0d", exp_q.size(), row);
				exp_q.delete();
			end
			for (int s = 0; s < STRANDS; s++)
			begin
				for (int r = 0; r < 8; r++)
					check_regs(seen_regs[s][r], model_regs[s][r],
						$sformatf("strand %0d r%0d", s, r));
				check_regs(seen_regs[s][result_reg(row_kind[row][s])], row_expect[row][s],
					$sformatf("strand %0d result register", s));
			end
			if (errors != errors_before)
				failed_tests++;
			$display("test %0d: %0d commits, %s", row, commits,
				(errors == errors_before) ? "ok" : "mismatches found");
		end
		$display("tests run: %0d, tests failed: %0d, errors: %0d", NUM_ROWS, failed_tests, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- source/strand_core.sv
`timescale 1ns/100ps

module strand_core
	#(parameter int NUM_STRANDS = 4)
	(input logic clk,
	input logic rst_n_i,
	input logic start_i,
	input core_pkg::word_t idata_i,
	output core_pkg::pc_t iaddress_o,
	output logic iaccess_o,
	output core_pkg::commit_t commit_o,
	output logic halt_o);

	import core_pkg::*;

	issue_t ss_issue;
	redirect_t rb_redirect;
	logic [NUM_STRANDS-1:0] halted;
	logic flush_ds;
	logic flush_ex;
	reg_idx_t rf_sel_a;
	reg_idx_t rf_sel_b;
	logic [STRAND_W-1:0] ds_strand;
	word_t rf_value_a;
	word_t rf_value_b;
	decoded_t ds_decoded;
	redirect_t ex_branch;
	halt_req_t ex_halt_req;
	commit_t ex_result;
	commit_t wb_commit;

	strand_select_stage #(.NUM_STRANDS(NUM_STRANDS)) ss(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.start_i(start_i),
		.redirect_i(rb_redirect),
		.halted_i(halted),
		.issue_o(ss_issue),
		.iaddress_o(iaddress_o),
		.iaccess_o(iaccess_o));

	decode_stage ds(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.issue_i(ss_issue),
		.idata_i(idata_i),
		.flush_i(flush_ds),
		.rf_a_i(rf_value_a),
		.rf_b_i(rf_value_b),
		.rf_sel_a_o(rf_sel_a),
		.rf_sel_b_o(rf_sel_b),
		.rf_strand_o(ds_strand),
		.decoded_o(ds_decoded));

	register_file #(.NUM_STRANDS(NUM_STRANDS)) rf(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.strand_i(ds_strand),
		.sel_a_i(rf_sel_a),
		.sel_b_i(rf_sel_b),
		.write_i(wb_commit),
		.value_a_o(rf_value_a),
		.value_b_o(rf_value_b));

	execute_stage exs(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.decoded_i(ds_decoded),
		.bypass_i(wb_commit),
		.flush_i(flush_ex),
		.branch_o(ex_branch),
		.halt_req_o(ex_halt_req),
		.result_o(ex_result));

	writeback_stage wbs(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.result_i(ex_result),
		.commit_o(wb_commit));

	rollback_controller #(.NUM_STRANDS(NUM_STRANDS)) rbc(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.start_i(start_i),
		.branch_i(ex_branch),
		.halt_req_i(ex_halt_req),
		.issue_strand_i(ss_issue.strand),
		.decode_strand_i(ds_strand),
		.flush_ds_o(flush_ds),
		.flush_ex_o(flush_ex),
		.redirect_o(rb_redirect),
		.halted_o(halted),
		.halt_o(halt_o));

	assign commit_o = wb_commit;

endmodule

//--- source/rollback_controller.sv
`timescale 1ns/100ps

module rollback_controller
	#(parameter int NUM_STRANDS = 4)
	(input logic clk,
	input logic rst_n_i,
	input logic start_i,
	input core_pkg::redirect_t branch_i,
	input core_pkg::halt_req_t halt_req_i,
	input logic [core_pkg::STRAND_W-1:0] issue_strand_i,
	input logic [core_pkg::STRAND_W-1:0] decode_strand_i,
	output logic flush_ds_o,
	output logic flush_ex_o,
	output core_pkg::redirect_t redirect_o,
	output logic [NUM_STRANDS-1:0] halted_o,
	output logic halt_o);

	import core_pkg::*;

	logic kill;
	logic [STRAND_W-1:0] kill_strand;
	logic [NUM_STRANDS-1:0] halted_q;
	logic [NUM_STRANDS-1:0] halted_next;
	logic flush_ds_q;
	logic flush_ex_q;
	logic halt_q;

	assign kill = branch_i.valid || halt_req_i.valid;
	assign kill_strand = branch_i.valid ? branch_i.strand : halt_req_i.strand;

	always_comb
	begin
		halted_next = halted_q;
		if (start_i)
			halted_next = '0;
		else if (halt_req_i.valid)
			halted_next[halt_req_i.strand] = 1'b1;
	end

	// flushes act one cycle later, when the matched entries have moved on a stage
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			flush_ds_q <= 1'b0;
			flush_ex_q <= 1'b0;
			halted_q <= '0;
			halt_q <= 1'b0;
		end
		else
		begin
			flush_ds_q <= kill && issue_strand_i == kill_strand;	// was in fetch
			flush_ex_q <= kill && decode_strand_i == kill_strand;	// was in decode
			halted_q <= halted_next;
			halt_q <= &halted_next;
		end
	end

	assign flush_ds_o = flush_ds_q;
	assign flush_ex_o = flush_ex_q;
	assign redirect_o = branch_i;	// strand select applies it at this edge
	assign halted_o = halted_q;
	assign halt_o = halt_q;

endmodule

//--- execute/writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage
	(input logic clk,
	input logic rst_n_i,
	input core_pkg::commit_t result_i,
	output core_pkg::commit_t commit_o);

	import core_pkg::*;

	commit_t commit_q;	// architectural write, bypass and top output

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			commit_q <= '0;
		else
			commit_q <= result_i;
	end

	assign commit_o = commit_q;

endmodule

//--- execute/execute_stage.sv
`timescale 1ns/100ps

module execute_stage
	(input logic clk,
	input logic rst_n_i,
	input core_pkg::decoded_t decoded_i,
	input core_pkg::commit_t bypass_i,
	input logic flush_i,
	output core_pkg::redirect_t branch_o,
	output core_pkg::halt_req_t halt_req_o,
	output core_pkg::commit_t result_o);

	import core_pkg::*;

	logic live;
	word_t op_a;
	word_t op_b;
	word_t result;
	pc_t target;

	assign live = decoded_i.valid && !flush_i;

	// the commit of the previous op was not yet in the register file at decode
	always_comb
	begin
		op_a = decoded_i.a;
		op_b = decoded_i.b;
		if (bypass_i.valid && bypass_i.strand == decoded_i.strand)
		begin
			if (bypass_i.rd == decoded_i.rs1)
				op_a = bypass_i.value;
			if (bypass_i.rd == decoded_i.rs2)
				op_b = bypass_i.value;
		end
	end

	always_comb
	begin
		case (decoded_i.op)
			OP_ADD: result = op_a + op_b;
			OP_SUB: result = op_a - op_b;
			OP_ADDI: result = op_a + decoded_i.imm;
			default: result = '0;
		endcase
	end

	assign target = decoded_i.pc + 8'd1 + decoded_i.imm[7:0];	// wraps at 256

	assign branch_o.valid = live && decoded_i.op == OP_BNZ && op_a != '0;
	assign branch_o.strand = decoded_i.strand;
	assign branch_o.target = target;

	assign halt_req_o.valid = live && decoded_i.op == OP_HALT;
	assign halt_req_o.strand = decoded_i.strand;

	assign result_o.valid = live && decoded_i.has_writeback;
	assign result_o.strand = decoded_i.strand;
	assign result_o.rd = decoded_i.rd;
	assign result_o.value = result;

	// op that followed a redirect or halt in the same strand never executes
	younger_op_killed: assert property (@(posedge clk) disable iff (!rst_n_i)
		(branch_o.valid || halt_req_o.valid) |=>
		!(live && decoded_i.strand == $past(decoded_i.strand)));

endmodule

//--- source/register_file.sv
`timescale 1ns/100ps

module register_file
	#(parameter int NUM_STRANDS = 4)
	(input logic clk,
	input logic rst_n_i,
	input logic [core_pkg::STRAND_W-1:0] strand_i,
	input core_pkg::reg_idx_t sel_a_i,
	input core_pkg::reg_idx_t sel_b_i,
	input core_pkg::commit_t write_i,
	output core_pkg::word_t value_a_o,
	output core_pkg::word_t value_b_o);

	import core_pkg::*;

	word_t bank_q [NUM_STRANDS][NUM_REGS];
	logic hit_a;
	logic hit_b;

	// write in the same cycle wins over the stored value
	assign hit_a = write_i.valid && write_i.strand == strand_i && write_i.rd == sel_a_i;
	assign hit_b = write_i.valid && write_i.strand == strand_i && write_i.rd == sel_b_i;

	assign value_a_o = hit_a ? write_i.value : bank_q[strand_i][sel_a_i];
	assign value_b_o = hit_b ? write_i.value : bank_q[strand_i][sel_b_i];

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
				for (int r = 0; r < NUM_REGS; r++)
					bank_q[s][r] <= '0;
		end
		else if (write_i.valid)
			bank_q[write_i.strand][write_i.rd] <= write_i.value;
	end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/100ps

module decode_stage
	(input logic clk,
	input logic rst_n_i,
	input core_pkg::issue_t issue_i,
	input core_pkg::word_t idata_i,
	input logic flush_i,
	input core_pkg::word_t rf_a_i,
	input core_pkg::word_t rf_b_i,
	output core_pkg::reg_idx_t rf_sel_a_o,
	output core_pkg::reg_idx_t rf_sel_b_o,
	output logic [core_pkg::STRAND_W-1:0] rf_strand_o,
	output core_pkg::decoded_t decoded_o);

	import core_pkg::*;

	issue_t issue_q;	// fetch entry, its word arrives this cycle
	instr_t instr;
	opcode_e op;
	logic writes;

	assign instr = instr_t'(idata_i);
	assign rf_strand_o = issue_q.strand;
	assign rf_sel_a_o = instr.rs1;
	assign rf_sel_b_o = instr.rs2;

	always_comb
	begin
		case (instr.op)
			OP_ADD, OP_SUB, OP_ADDI, OP_BNZ, OP_HALT: op = opcode_e'(instr.op);
			default: op = OP_NOP;	// unknown codes retire as nop
		endcase
	end

	assign writes = op inside {OP_ADD, OP_SUB, OP_ADDI};

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			issue_q <= '0;
			decoded_o <= '0;
		end
		else
		begin
			issue_q <= issue_i;
			decoded_o.valid <= issue_q.valid && !flush_i;
			decoded_o.strand <= issue_q.strand;
			decoded_o.pc <= issue_q.pc;
			decoded_o.op <= op;
			decoded_o.rd <= instr.rd;
			decoded_o.rs1 <= instr.rs1;
			decoded_o.rs2 <= instr.rs2;
			decoded_o.a <= rf_a_i;
			decoded_o.b <= rf_b_i;
			decoded_o.imm <= {{16{instr.imm[15]}}, instr.imm};
			decoded_o.has_writeback <= writes;
		end
	end

endmodule

//--- source/strand_select_stage.sv
`timescale 1ns/100ps

module strand_select_stage
	#(parameter int NUM_STRANDS = 4)
	(input logic clk,
	input logic rst_n_i,
	input logic start_i,
	input core_pkg::redirect_t redirect_i,
	input logic [NUM_STRANDS-1:0] halted_i,
	output core_pkg::issue_t issue_o,
	output core_pkg::pc_t iaddress_o,
	output logic iaccess_o);

	import core_pkg::*;

	pc_t pc_q [NUM_STRANDS];
	logic [STRAND_W-1:0] rr_q;	// first strand to consider
	logic [STRAND_W-1:0] sel;
	logic running_q;
	logic found;
	logic [NUM_STRANDS-1:0] eligible;

	assign eligible = running_q ? ~halted_i : '0;

	always_comb
	begin
		int unsigned idx;
		sel = rr_q;
		found = 1'b0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			idx = (int'(rr_q) + i) % NUM_STRANDS;
			if (!found && eligible[idx])
			begin
				sel = STRAND_W'(idx);
				found = 1'b1;
			end
		end
	end

	assign issue_o = '{valid: found, strand: sel, pc: pc_q[sel]};
	assign iaddress_o = pc_q[sel];
	assign iaccess_o = found;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			running_q <= 1'b0;
			rr_q <= '0;
			for (int s = 0; s < NUM_STRANDS; s++)
				pc_q[s] <= '0;
		end
		else if (start_i)
		begin
			running_q <= 1'b1;
			rr_q <= '0;
			for (int s = 0; s < NUM_STRANDS; s++)
				pc_q[s] <= pc_t'(s << STRAND_BASE_SHIFT);
		end
		else
		begin
			if (found)
			begin
				pc_q[sel] <= pc_q[sel] + 8'd1;
				rr_q <= STRAND_W'((int'(sel) + 1) % NUM_STRANDS);
			end
			if (redirect_i.valid)
				pc_q[redirect_i.strand] <= redirect_i.target;	// overrides the increment
		end
	end

	// once every strand is halted no fetch follows until the next start
	no_fetch_when_halted: assert property (@(posedge clk) disable iff (!rst_n_i)
		&halted_i && !start_i |=> !iaccess_o);

endmodule

//--- common/core_pkg.sv
package core_pkg;

	localparam int STRAND_W = 2;
	localparam int STRAND_BASE_SHIFT = 6;	// strand s starts at s * 64
	localparam int NUM_REGS = 8;

	typedef logic [7:0] pc_t;	// word address
	typedef logic [2:0] reg_idx_t;
	typedef logic [31:0] word_t;

	typedef enum logic [3:0] {
		OP_NOP = 4'h0,
		OP_ADD = 4'h1,
		OP_SUB = 4'h2,
		OP_ADDI = 4'h3,
		OP_BNZ = 4'h4,
		OP_HALT = 4'h5
	} opcode_e;

	typedef struct packed {
		logic [3:0] op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic [2:0] unused;
		logic [15:0] imm;
	} instr_t;

	typedef struct packed {
		logic valid;
		logic [STRAND_W-1:0] strand;
		pc_t pc;
	} issue_t;

	typedef struct packed {
		logic valid;
		logic [STRAND_W-1:0] strand;
		pc_t pc;
		opcode_e op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t a;
		word_t b;
		word_t imm;	// sign extended
		logic has_writeback;
	} decoded_t;

	typedef struct packed {
		logic valid;
		logic [STRAND_W-1:0] strand;
		reg_idx_t rd;
		word_t value;
	} commit_t;

	typedef struct packed {
		logic valid;
		logic [STRAND_W-1:0] strand;
		pc_t target;
	} redirect_t;

	typedef struct packed {
		logic valid;
		logic [STRAND_W-1:0] strand;
	} halt_req_t;

endpackage
